//--- logic/wrap_cfg_pkg.sv
package wrap_cfg_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  // External slave ports
  localparam int unsigned NumSlv      = 4;
  localparam int unsigned SlvIdxWidth = 2;

  // Address region field, one region per slave
  localparam int unsigned RegionMsb   = 15;
  localparam int unsigned RegionLsb   = 12;
  localparam int unsigned RegionWidth = RegionMsb - RegionLsb + 1;

  // Slave k owns region k, regions NumSlv and up are unmapped

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [SelWidth-1:0]    sel_t;
  typedef logic [RegionWidth-1:0] region_t;

  // Index of one slave port
  typedef logic [SlvIdxWidth-1:0] slv_idx_t;

  // One bit per slave port
  typedef logic [NumSlv-1:0] slv_mask_t;

endpackage

//--- logic/wb_bus_pkg.sv
package wb_bus_pkg;

  import wrap_cfg_pkg::*;

  // Wishbone classic request, held by the master until ack or err
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  // Wishbone classic response
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // Locally generated error, data is zero
  localparam wb_rsp_t WbRspErr = '{
    ack: 1'b0,
    err: 1'b1,
    dat: '0
  };

endpackage

//--- logic/slave_decoder.sv
`timescale 1ns/1ps

module slave_decoder
  import wrap_cfg_pkg::*;
(
  input  logic [AddrWidth-1:0] adr_i,
  output slv_idx_t             idx_o,
  output logic                 hit_o
);

  region_t region;

  // Region field only, the offset inside a region is the slave's business
  assign region = adr_i[RegionMsb:RegionLsb];

  // Slave k owns region k
  always_comb begin
    hit_o = 1'b0;
    idx_o = '0;
    for (int k = 0; k < NumSlv; k++) begin
      if (region == region_t'(k)) begin
        hit_o = 1'b1;
        idx_o = slv_idx_t'(k);
      end
    end
  end

endmodule

//--- logic/isolate_ctrl.sv
`timescale 1ns/1ps

module isolate_ctrl
  import wrap_cfg_pkg::*;
  import wb_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  wb_req_t   mst_req_i,
  input  slv_idx_t  idx_i,
  input  logic      hit_i,
  input  logic      slv_done_i,
  input  slv_mask_t isolate_i,
  output logic      forward_o,
  output logic      terminate_o,
  output slv_mask_t isolated_o
);

  logic      req_valid;
  logic      first;
  logic      blocked;
  logic      fwd_new;
  logic      done;
  logic      active_q;
  logic      fwd_q;
  slv_mask_t inflight;
  slv_mask_t isolated_q;

  assign req_valid = mst_req_i.cyc & mst_req_i.stb;

  // First cycle of an access, nothing decided yet
  assign first = req_valid & ~active_q;

  // A raised request blocks at once, even before isolation is granted
  assign blocked = isolate_i[idx_i] | isolated_q[idx_i];
  assign fwd_new = hit_i & ~blocked;

  // Decide in the first cycle, then follow the stored decision
  always_comb begin
    if (first) begin
      forward_o   = fwd_new;
      terminate_o = ~fwd_new;
    end else begin
      forward_o   = req_valid & active_q & fwd_q;
      terminate_o = req_valid & active_q & ~fwd_q;
    end
  end

  // Only a forwarded access can be ended by the slave
  assign done = slv_done_i & forward_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      fwd_q    <= 1'b0;
    end else if (first) begin
      // Zero wait slave ends the cycle right here
      active_q <= ~done;
      fwd_q    <= fwd_new;
    end else if (active_q) begin
      // Local error takes one more cycle
      if (!req_valid || !fwd_q || done) begin
        active_q <= 1'b0;
      end
    end
  end

  // Forwarded access still open towards each slave, ack cycle included
  always_comb begin
    inflight = '0;
    if (forward_o) begin
      inflight[idx_i] = 1'b1;
    end
  end

  // Grant isolation once the port has drained, drop it with the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      isolated_q <= '0;
    end else begin
      isolated_q <= isolate_i & (isolated_q | ~inflight);
    end
  end

  assign isolated_o = isolated_q;

endmodule

//--- logic/req_fanout.sv
`timescale 1ns/1ps

module req_fanout
  import wrap_cfg_pkg::*;
  import wb_bus_pkg::*;
(
  input  wb_req_t               mst_req_i,
  input  slv_idx_t              idx_i,
  input  logic                  forward_i,
  output wb_req_t [NumSlv-1:0]  slv_req_o
);

  slv_mask_t sel;

  // One-hot target, empty unless the access is forwarded
  always_comb begin
    sel = '0;
    if (forward_i) begin
      sel[idx_i] = 1'b1;
    end
  end

  // Payload goes everywhere, only the target sees a cycle
  always_comb begin
    for (int k = 0; k < NumSlv; k++) begin
      slv_req_o[k]     = mst_req_i;
      slv_req_o[k].cyc = mst_req_i.cyc & sel[k];
      slv_req_o[k].stb = mst_req_i.stb & sel[k];
    end
  end

endmodule

//--- logic/rsp_mux.sv
`timescale 1ns/1ps

module rsp_mux
  import wrap_cfg_pkg::*;
  import wb_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  wb_req_t               mst_req_i,
  input  slv_idx_t              idx_i,
  input  logic                  terminate_i,
  input  wb_rsp_t [NumSlv-1:0]  slv_rsp_i,
  output wb_rsp_t               mst_rsp_o
);

  logic    err_q;
  logic    fwd_sel;
  wb_rsp_t sel_rsp;

  assign sel_rsp = slv_rsp_i[idx_i];

  // Access currently owned by the selected slave
  assign fwd_sel = mst_req_i.cyc & mst_req_i.stb & ~terminate_i;

  // One cycle error pulse, one cycle after stb, self clearing
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= terminate_i & mst_req_i.stb & ~err_q;
    end
  end

  always_comb begin
    mst_rsp_o = '0;
    if (err_q) begin
      mst_rsp_o = WbRspErr;
    end else if (fwd_sel) begin
      mst_rsp_o = sel_rsp;
    end
  end

endmodule

//--- logic/ext_port_wrap.sv
`timescale 1ns/1ps

module ext_port_wrap
  import wrap_cfg_pkg::*;
  import wb_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  wb_req_t               mst_req_i,
  output wb_rsp_t               mst_rsp_o,
  output wb_req_t [NumSlv-1:0]  slv_req_o,
  input  wb_rsp_t [NumSlv-1:0]  slv_rsp_i,
  input  slv_mask_t             isolate_i,
  output slv_mask_t             isolated_o
);

  slv_idx_t idx;
  logic     hit;
  logic     forward;
  logic     terminate;
  logic     slv_done;

  // Either ack or err from the target ends the cycle
  assign slv_done = slv_rsp_i[idx].ack | slv_rsp_i[idx].err;

  slave_decoder i_slave_decoder (
    .adr_i ( mst_req_i.adr ),
    .idx_o ( idx           ),
    .hit_o ( hit           )
  );

  isolate_ctrl i_isolate_ctrl (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .mst_req_i   ( mst_req_i  ),
    .idx_i       ( idx        ),
    .hit_i       ( hit        ),
    .slv_done_i  ( slv_done   ),
    .isolate_i   ( isolate_i  ),
    .forward_o   ( forward    ),
    .terminate_o ( terminate  ),
    .isolated_o  ( isolated_o )
  );

  req_fanout i_req_fanout (
    .mst_req_i ( mst_req_i ),
    .idx_i     ( idx       ),
    .forward_i ( forward   ),
    .slv_req_o ( slv_req_o )
  );

  rsp_mux i_rsp_mux (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .mst_req_i   ( mst_req_i ),
    .idx_i       ( idx       ),
    .terminate_i ( terminate ),
    .slv_rsp_i   ( slv_rsp_i ),
    .mst_rsp_o   ( mst_rsp_o )
  );

endmodule

//--- dv/ext_port_asserts.sv
`timescale 1ns/1ps

module ext_port_asserts
  import wrap_cfg_pkg::*;
  import wb_bus_pkg::*;
(
  input logic                 clk_i,
  input logic                 reset_i,
  input wb_rsp_t              mst_rsp_i,
  input wb_req_t [NumSlv-1:0] slv_req_i,
  input slv_mask_t            isolated_i
);

  slv_mask_t cyc_vec;

  always_comb begin
    for (int k = 0; k < NumSlv; k++) begin
      cyc_vec[k] = slv_req_i[k].cyc;
    end
  end

  ack_err_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(mst_rsp_i.ack && mst_rsp_i.err))
    else $error("ack and err high together");

  // Isolated port never sees traffic
  no_cyc_isolated: assert property (@(posedge clk_i) disable iff (reset_i)
    (cyc_vec & isolated_i) == '0)
    else $error("cyc reaches an isolated slave");

  one_slave_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(cyc_vec))
    else $error("more than one slave sees cyc");

endmodule

//--- dv/tb_ext_port_wrap.sv
`timescale 1ns/1ps

module tb_ext_port_wrap
  import wrap_cfg_pkg::*;
  import wb_bus_pkg::*;
();

  localparam int     HalfPeriod  = 20;
  localparam int     SampleDelay = 10;
  localparam int     NumRandom   = 200;
  localparam int     NumAccess   = 300;
  localparam longint TimeoutNs   = longint'(NumAccess) * 8 * 2 * HalfPeriod + 4000;

  logic                 clk;
  logic                 reset;
  wb_req_t              mst_req;
  wb_rsp_t              mst_rsp;
  wb_req_t [NumSlv-1:0] slv_req;
  wb_rsp_t [NumSlv-1:0] slv_rsp;
  slv_mask_t            isolate;
  slv_mask_t            isolated;

  // Slave models
  data_t     slv_mem [NumSlv][16];
  int        wait_left [NumSlv];
  wb_req_t   cap_req [NumSlv];
  slv_mask_t stall;
  slv_mask_t seen;
  slv_mask_t fire;
  int        slv_cyc_cnt;

  // Reference model and bookkeeping
  data_t     ref_mem [NumSlv][16];
  slv_mask_t exp_iso;
  slv_mask_t iso_at_end;
  int        err_cnt;
  int        check_cnt;
  int        test_cnt;
  int        test_err_base;

  ext_port_wrap dut0 (
    .clk_i      ( clk      ),
    .reset_i    ( reset    ),
    .mst_req_i  ( mst_req  ),
    .mst_rsp_o  ( mst_rsp  ),
    .slv_req_o  ( slv_req  ),
    .slv_rsp_i  ( slv_rsp  ),
    .isolate_i  ( isolate  ),
    .isolated_o ( isolated )
  );

  bind ext_port_wrap ext_port_asserts i_ext_port_asserts (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .mst_rsp_i  ( mst_rsp_o  ),
    .slv_req_i  ( slv_req_o  ),
    .isolated_i ( isolated_o )
  );

  initial clk = 1'b0;
  always #HalfPeriod clk = ~clk;

  function automatic data_t fill_word(input int slv, input int word);
    return {8'hc0, 8'(slv), 8'(word), 8'(slv * 16 + word) ^ 8'h5a};
  endfunction

  // Ack as soon as the wait count has run out
  always_comb begin
    logic ack;
    for (int k = 0; k < NumSlv; k++) begin
      ack = slv_req[k].cyc & slv_req[k].stb & ~stall[k] & (wait_left[k] == 0);
      slv_rsp[k].ack = ack;
      slv_rsp[k].err = 1'b0;
      slv_rsp[k].dat = '0;
      if (ack && !slv_req[k].we) begin
        slv_rsp[k].dat = slv_mem[k][slv_req[k].adr[5:2]];
      end
    end
  end

  initial begin
    for (int k = 0; k < NumSlv; k++) begin
      wait_left[k] = 0;
      for (int w = 0; w < 16; w++) begin
        slv_mem[k][w] = fill_word(k, w);
      end
    end
    seen = '0;
    fire = '0;
    slv_cyc_cnt = 0;
    forever begin
      @(negedge clk);
      // Commit what the last rising edge accepted
      for (int k = 0; k < NumSlv; k++) begin
        if (fire[k]) begin
          if (cap_req[k].we) begin
            slv_mem[k][cap_req[k].adr[5:2]] = cap_req[k].dat;
          end
          wait_left[k] = int'($urandom % 4);
        end else if (seen[k] && wait_left[k] > 0) begin
          wait_left[k]--;
        end
      end
      #SampleDelay;
      for (int k = 0; k < NumSlv; k++) begin
        seen[k] = slv_req[k].cyc & slv_req[k].stb;
        fire[k] = seen[k] & slv_rsp[k].ack;
        cap_req[k] = slv_req[k];
      end
      if (seen != '0) begin
        slv_cyc_cnt++;
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // Runs from a falling edge to a falling edge with one idle cycle
  task automatic do_access(input logic we, input addr_t adr, input data_t wdat,
                           output wb_rsp_t rsp);
    logic ended;
    ended = 1'b0;
    mst_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: '1, adr: adr, dat: wdat};
    while (!ended) begin
      #SampleDelay;
      if (mst_rsp.ack || mst_rsp.err) begin
        rsp = mst_rsp;
        iso_at_end = isolated;
        ended = 1'b1;
      end
      @(negedge clk);
    end
    mst_req = '0;
    @(negedge clk);
  endtask

  task automatic run_access(input logic we, input int region, input logic [3:0] word);
    addr_t    adr;
    data_t    wdat;
    wb_rsp_t  rsp;
    slv_idx_t si;
    logic     exp_err;
    int       cyc_before;
    si = slv_idx_t'(region);
    adr = {4'(region), 6'($urandom), word, 2'b00};
    wdat = $urandom;
    exp_err = (region >= NumSlv) || isolate[si] || exp_iso[si];
    cyc_before = slv_cyc_cnt;
    do_access(we, adr, wdat, rsp);
    check_value("mst_rsp_o.ack", 64'(rsp.ack), 64'(!exp_err));
    check_value("mst_rsp_o.err", 64'(rsp.err), 64'(exp_err));
    if (exp_err) begin
      check_value("mst_rsp_o.dat", 64'(rsp.dat), 64'(0));
      check_value("slave cycles", 64'(slv_cyc_cnt), 64'(cyc_before));
    end else if (we) begin
      ref_mem[si][word] = wdat;
    end else begin
      check_value("mst_rsp_o.dat", 64'(rsp.dat), 64'(ref_mem[si][word]));
    end
  endtask

  initial begin
    slv_idx_t iso_a;
    slv_idx_t iso_b;
    void'($urandom(52));
    reset = 1'b1;
    // Unmapped access and isolation requests pending while in reset
    mst_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: '1, adr: 16'hf000, dat: '0};
    isolate = '1;
    stall = '0;
    exp_iso = '0;
    iso_at_end = '0;
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    test_err_base = 0;
    iso_a = 2'd2;
    iso_b = 2'd1;
    for (int k = 0; k < NumSlv; k++) begin
      for (int w = 0; w < 16; w++) begin
        ref_mem[k][w] = fill_word(k, w);
      end
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    mst_req = '0;
    isolate = '0;

    repeat (4) begin
      #SampleDelay;
      check_value("isolated_o", 64'(isolated), 64'(0));
      check_value("mst_rsp_o.ack", 64'(mst_rsp.ack), 64'(0));
      check_value("mst_rsp_o.err", 64'(mst_rsp.err), 64'(0));
      @(negedge clk);
    end
    check_value("slave cycles", 64'(slv_cyc_cnt), 64'(0));
    finish_test("reset state");

    repeat (NumRandom) run_access(1'($urandom), int'($urandom % NumSlv), 4'($urandom));
    finish_test("random access");

    repeat (16) begin
      run_access(1'($urandom), int'(NumSlv + $urandom % (16 - NumSlv)), 4'($urandom));
    end
    finish_test("decode miss");

    // Idle slave is granted after one edge
    isolate[iso_a] = 1'b1;
    #SampleDelay;
    check_value("isolated_o", 64'(isolated), 64'(exp_iso));
    @(negedge clk);
    #SampleDelay;
    exp_iso[iso_a] = 1'b1;
    check_value("isolated_o", 64'(isolated), 64'(exp_iso));
    @(negedge clk);
    run_access(1'b0, int'(iso_a), 4'($urandom));
    run_access(1'b1, int'(iso_a), 4'($urandom));
    repeat (24) run_access(1'($urandom), int'($urandom % NumSlv), 4'($urandom));
    finish_test("isolate idle slave");

    // Request arrives while the slave is holding off its ack
    stall[iso_b] = 1'b1;
    fork
      run_access(1'b0, int'(iso_b), 4'($urandom));
      begin
        repeat (2) @(negedge clk);
        isolate[iso_b] = 1'b1;
        repeat (3) begin
          #SampleDelay;
          check_value("isolated_o", 64'(isolated), 64'(exp_iso));
          @(negedge clk);
        end
        stall[iso_b] = 1'b0;
      end
    join
    check_value("isolated_o at ack", 64'(iso_at_end), 64'(exp_iso));
    exp_iso[iso_b] = 1'b1;
    #SampleDelay;
    check_value("isolated_o", 64'(isolated), 64'(exp_iso));
    @(negedge clk);
    finish_test("isolate during access");

    isolate = '0;
    #SampleDelay;
    check_value("isolated_o", 64'(isolated), 64'(exp_iso));
    @(negedge clk);
    #SampleDelay;
    exp_iso = '0;
    check_value("isolated_o", 64'(isolated), 64'(exp_iso));
    @(negedge clk);
    for (int w = 0; w < 16; w++) begin
      run_access(1'b0, int'(iso_a), 4'(w));
      run_access(1'b0, int'(iso_b), 4'(w));
    end
    repeat (16) run_access(1'($urandom), int'($urandom % NumSlv), 4'($urandom));
    finish_test("release isolation");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("timeout after %0d ns, an access never finished", TimeoutNs);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- sim.f
logic/wrap_cfg_pkg.sv
logic/wb_bus_pkg.sv
logic/slave_decoder.sv
logic/isolate_ctrl.sv
logic/req_fanout.sv
logic/rsp_mux.sv
logic/ext_port_wrap.sv
dv/ext_port_asserts.sv
dv/tb_ext_port_wrap.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ext_port_wrap \
  --Mdir obj_dir \
  -f sim.f

./obj_dir/Vtb_ext_port_wrap | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
